// File: include/shadow_cfg.svh
/*
 * Address map and RAM sizing for the Apple II video shadow.
 * Hires covers 2000-5FFF only, 16K per bank; text covers 0400-0BFF
 * with main and aux bytes interleaved in one RAM.
 * RAM widths count 32-bit words.
 */
`ifndef SHADOW_CFG_SVH
`define SHADOW_CFG_SVH

// Soft-switch pages matched against addr[15:4]
`define SW_II_PAGE      12'hC05
`define SW_IIE_PAGE     12'hC00

// Keyboard data and strobe-clear addresses
`define KBD_DATA_ADDR   16'hC000
`define KBD_CLEAR_ADDR  16'hC010

// Shadowed regions of the 6502 address space
`define TEXT_LO         16'h0400
`define TEXT_HI         16'h0BFF
`define HIRES_LO        16'h2000
`define HIRES_HI        16'h5FFF

// Word address widths of the shadow RAMs
`define TEXT_RAM_AW     10
`define HIRES_RAM_AW    12

`endif

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator; the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_apple_shadow \
    -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
echo "Build or simulation returned an error, see build.log and sim.log"
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: source/a2_shadow_pkg.sv
/*
 * Types shared by the shadow memory blocks and their testbench.
 * Switch structs are declared highest switch first, so a cast to
 * logic [7:0] indexes them by soft-switch number.
 */
package a2_shadow_pkg;

    // One sample of the Apple II bus
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rw_n;
        logic        data_in_strobe;
        logic        phi1_posedge;
        logic        m2sel_n;
        logic        m2b0;
    } a2_bus_t;

    // Original II switches at C050-C05F
    typedef struct packed {
        logic an3;
        logic an2;
        logic an1;
        logic an0;
        logic hires;
        logic page2;
        logic mixed;
        logic text;
    } ii_switches_t;

    // IIe switches written at C000-C00F
    typedef struct packed {
        logic altchar;
        logic col80;
        logic slotc3rom;
        logic altzp;
        logic intcxrom;
        logic ramwrt;
        logic ramrd;
        logic store80;
    } iie_switches_t;

    typedef struct packed {
        logic [7:0] keycode;
        logic       keypress;
    } key_t;

    typedef enum logic [1:0] {
        REGION_NONE  = 2'd0,
        REGION_TEXT  = 2'd1,
        REGION_HIRES = 2'd2
    } shadow_region_e;

    // Write handed from the scheduler to the shadow RAMs
    typedef struct packed {
        shadow_region_e region;
        logic [11:0]    offset;
        logic [1:0]     lane;
        logic           aux;
        logic [7:0]     data;
        logic           valid;
        logic [1:0]     spare;
    } shadow_write_t;

    // Video scanner read request
    typedef struct packed {
        logic [15:0] addr;
        logic        rd;
    } video_req_t;

endpackage

// File: source/apple_shadow_top.sv
/*
 * Apple II bus snooper with the FPGA shadow of video memory.
 * The bus is sampled every clock with no handshake. Shadow writes
 * wait while the scanner reads, one write in flight at a time.
 */
`timescale 1ns/1ps

module apple_shadow_top
    import a2_shadow_pkg::*;
(
    input  logic          a2bus_if,
    input  logic          rst_n_i,
    input  a2_bus_t       bus_i,
    input  video_req_t    video_i,
    output ii_switches_t  ii_sw_o,
    output iie_switches_t iie_sw_o,
    output logic          aux_mem_o,
    output key_t          key_o,
    output logic [31:0]   video_data_o
);

    shadow_write_t shadow_wr;

    soft_switches u_soft_switches (
        .a2bus_if  (a2bus_if),
        .rst_n_i   (rst_n_i),
        .bus_i     (bus_i),
        .ii_sw_o   (ii_sw_o),
        .iie_sw_o  (iie_sw_o),
        .aux_mem_o (aux_mem_o)
    );

    keyboard_latch u_keyboard_latch (
        .a2bus_if (a2bus_if),
        .rst_n_i  (rst_n_i),
        .bus_i    (bus_i),
        .key_o    (key_o)
    );

    write_scheduler u_write_scheduler (
        .a2bus_if   (a2bus_if),
        .rst_n_i    (rst_n_i),
        .bus_i      (bus_i),
        .aux_mem_i  (aux_mem_o),
        .video_rd_i (video_i.rd),
        .wr_o       (shadow_wr)
    );

    video_shadow u_video_shadow (
        .a2bus_if     (a2bus_if),
        .rst_n_i      (rst_n_i),
        .wr_i         (shadow_wr),
        .video_i      (video_i),
        .video_data_o (video_data_o)
    );

endmodule

// File: source/keyboard_latch.sv
/*
 * Snoops C000 reads for a fresh keycode and C010 for the strobe clear.
 * A new key is taken only while the latched bit 7 is clear.
 */
`timescale 1ns/1ps
`include "shadow_cfg.svh"

module keyboard_latch
    import a2_shadow_pkg::*;
(
    input  logic    a2bus_if,
    input  logic    rst_n_i,
    input  a2_bus_t bus_i,
    output key_t    key_o
);

    logic [7:0] keycode_r;
    logic       keypress_r;
    logic       read_strobe;

    assign read_strobe = bus_i.rw_n && bus_i.data_in_strobe;

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            keycode_r  <= 8'h00;
            keypress_r <= 1'b0;
        end else begin
            keypress_r <= 1'b0;
            if (read_strobe && (bus_i.addr == `KBD_DATA_ADDR)) begin
                if (bus_i.data[7] && !keycode_r[7]) begin
                    keycode_r  <= bus_i.data;
                    keypress_r <= 1'b1;
                end
            end else if (bus_i.data_in_strobe && (bus_i.addr == `KBD_CLEAR_ADDR)) begin
                keycode_r[7] <= 1'b0;
            end
        end
    end

    assign key_o = '{keycode: keycode_r, keypress: keypress_r};

endmodule

// File: source/sdpram32.sv
/*
 * Simple dual-port block RAM of 32-bit words.
 * Per-byte write enables, read registered on read_enable_i.
 * Read and write of the same word in one cycle returns old data.
 */
`timescale 1ns/1ps

module sdpram32 #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  a2bus_if,
    input  logic [ADDR_WIDTH-1:0] write_addr_i,
    input  logic [31:0]           write_data_i,
    input  logic                  write_enable_i,
    input  logic [3:0]            byte_enable_i,
    input  logic [ADDR_WIDTH-1:0] read_addr_i,
    input  logic                  read_enable_i,
    output logic [31:0]           read_data_o
);

    logic [31:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge a2bus_if) begin
        if (write_enable_i) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_enable_i[b]) begin
                    mem[write_addr_i][b*8 +: 8] <= write_data_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (read_enable_i) begin
            read_data_o <= mem[read_addr_i];
        end
    end

endmodule

// File: source/soft_switches.sv
/*
 * II and IIe soft-switch registers with the aux bank decode.
 * II switches change on any access in C05x, IIe switches only on
 * writes in C00x. aux_mem_o is combinational on the current bus
 * sample; it does not include m2b0.
 */
`timescale 1ns/1ps
`include "shadow_cfg.svh"

module soft_switches
    import a2_shadow_pkg::*;
(
    input  logic          a2bus_if,
    input  logic          rst_n_i,
    input  a2_bus_t       bus_i,
    output ii_switches_t  ii_sw_o,
    output iie_switches_t iie_sw_o,
    output logic          aux_mem_o
);

    logic [7:0] ii_r;
    logic [7:0] iie_r;
    logic       sw_access;
    logic       bus_wr;

    assign sw_access = bus_i.phi1_posedge && !bus_i.m2sel_n;
    assign bus_wr    = !bus_i.rw_n;

    // Odd address sets the switch, even address clears it
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // Text mode with AN3 high
            ii_r <= 8'b1000_0001;
        end else if (sw_access && (bus_i.addr[15:4] == `SW_II_PAGE)) begin
            ii_r[bus_i.addr[3:1]] <= bus_i.addr[0];
        end
    end

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            iie_r <= 8'h00;
        end else if (sw_access && bus_wr && (bus_i.addr[15:4] == `SW_IIE_PAGE)) begin
            iie_r[bus_i.addr[3:1]] <= bus_i.addr[0];
        end
    end

    assign ii_sw_o  = ii_switches_t'(ii_r);
    assign iie_sw_o = iie_switches_t'(iie_r);

    // Bank decode by page
    always_comb begin
        if ((bus_i.addr[15:9] == 7'b0000000) || (bus_i.addr[15:14] == 2'b11)) begin
            // Zero page, stack and the C0-FF space
            aux_mem_o = iie_sw_o.altzp;
        end else if (bus_i.addr[15:10] == 6'b000001) begin
            // Text page 1
            aux_mem_o = iie_sw_o.store80 ? ii_sw_o.page2 : (iie_sw_o.ramwrt && bus_wr);
        end else if (bus_i.addr[15:13] == 3'b001) begin
            // Hires page 1, follows page2 only with store80 and hires
            if (iie_sw_o.store80 && ii_sw_o.hires) begin
                aux_mem_o = ii_sw_o.page2;
            end else begin
                aux_mem_o = iie_sw_o.ramwrt && bus_wr;
            end
        end else begin
            aux_mem_o = iie_sw_o.ramwrt && bus_wr;
        end
    end

    // A IIe switch can only move after a write cycle on the bus
    a_iie_on_write: assert property (
        @(posedge a2bus_if) disable iff (!rst_n_i)
        (iie_r != $past(iie_r)) |-> $past(bus_wr && sw_access)
    );

endmodule

// File: source/video_shadow.sv
/*
 * Text and hires shadow RAMs with the video read path.
 * Read data is valid one cycle after a cycle with video_i.rd high.
 * Hires reads return main and aux bytes interleaved, aux above main;
 * addresses outside both regions read as zero.
 */
`timescale 1ns/1ps
`include "shadow_cfg.svh"

module video_shadow
    import a2_shadow_pkg::*;
(
    input  logic          a2bus_if,
    input  logic          rst_n_i,
    input  shadow_write_t wr_i,
    input  video_req_t    video_i,
    output logic [31:0]   video_data_o
);

    logic [31:0]              write_word;
    logic [3:0]               byte_en;
    logic                     text_we;
    logic                     hires_main_we;
    logic                     hires_aux_we;

    shadow_region_e           rd_region;
    logic [`TEXT_RAM_AW-1:0]  text_rd_off;
    logic [15:0]              hires_rel;
    logic [`HIRES_RAM_AW-1:0] hires_rd_off;
    logic                     text_re;
    logic                     hires_re;

    shadow_region_e           rd_region_q;
    logic                     half_q;
    logic [31:0]              text_data;
    logic [31:0]              hires_main_data;
    logic [31:0]              hires_aux_data;

    function automatic logic [31:0] interleave(input logic hi,
                                               input logic [31:0] main_w,
                                               input logic [31:0] aux_w);
        if (hi) begin
            return {aux_w[31:24], main_w[31:24], aux_w[23:16], main_w[23:16]};
        end
        return {aux_w[15:8], main_w[15:8], aux_w[7:0], main_w[7:0]};
    endfunction

    // Write side
    assign write_word    = {4{wr_i.data}};
    assign byte_en       = 4'b0001 << wr_i.lane;
    assign text_we       = wr_i.valid && (wr_i.region == REGION_TEXT);
    assign hires_main_we = wr_i.valid && (wr_i.region == REGION_HIRES) && !wr_i.aux;
    assign hires_aux_we  = wr_i.valid && (wr_i.region == REGION_HIRES) && wr_i.aux;

    // Read side
    always_comb begin
        rd_region = REGION_NONE;
        if ((video_i.addr >= `TEXT_LO) && (video_i.addr <= `TEXT_HI)) begin
            rd_region = REGION_TEXT;
        end else if ((video_i.addr >= `HIRES_LO) && (video_i.addr <= `HIRES_HI)) begin
            rd_region = REGION_HIRES;
        end
    end

    assign text_rd_off  = {!video_i.addr[10], video_i.addr[9:1]};
    assign hires_rel    = video_i.addr - `HIRES_LO;
    assign hires_rd_off = hires_rel[`HIRES_RAM_AW+1:2];
    assign text_re      = video_i.rd && (rd_region == REGION_TEXT);
    assign hires_re     = video_i.rd && (rd_region == REGION_HIRES);

    // Region and half travel with the RAM read
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_region_q <= REGION_NONE;
            half_q      <= 1'b0;
        end else if (video_i.rd) begin
            rd_region_q <= rd_region;
            half_q      <= video_i.addr[1];
        end
    end

    always_comb begin
        case (rd_region_q)
            REGION_TEXT:  video_data_o = text_data;
            REGION_HIRES: video_data_o = interleave(half_q, hires_main_data, hires_aux_data);
            default:      video_data_o = 32'h0;
        endcase
    end

    sdpram32 #(.ADDR_WIDTH(`TEXT_RAM_AW)) text_vram (
        .a2bus_if       (a2bus_if),
        .write_addr_i   (wr_i.offset[`TEXT_RAM_AW-1:0]),
        .write_data_i   (write_word),
        .write_enable_i (text_we),
        .byte_enable_i  (byte_en),
        .read_addr_i    (text_rd_off),
        .read_enable_i  (text_re),
        .read_data_o    (text_data)
    );

    sdpram32 #(.ADDR_WIDTH(`HIRES_RAM_AW)) hires_main (
        .a2bus_if       (a2bus_if),
        .write_addr_i   (wr_i.offset),
        .write_data_i   (write_word),
        .write_enable_i (hires_main_we),
        .byte_enable_i  (byte_en),
        .read_addr_i    (hires_rd_off),
        .read_enable_i  (hires_re),
        .read_data_o    (hires_main_data)
    );

    sdpram32 #(.ADDR_WIDTH(`HIRES_RAM_AW)) hires_aux (
        .a2bus_if       (a2bus_if),
        .write_addr_i   (wr_i.offset),
        .write_data_i   (write_word),
        .write_enable_i (hires_aux_we),
        .byte_enable_i  (byte_en),
        .read_addr_i    (hires_rd_off),
        .read_enable_i  (hires_re),
        .read_data_o    (hires_aux_data)
    );

endmodule

// File: source/write_scheduler.sv
/*
 * Captures bus writes into the shadow regions and holds them until
 * the video scanner is not reading. One write can be pending; the
 * bus must not strobe another shadow write before it commits.
 * wr_o.valid is combinational on video_rd_i.
 */
`timescale 1ns/1ps
`include "shadow_cfg.svh"

module write_scheduler
    import a2_shadow_pkg::*;
(
    input  logic          a2bus_if,
    input  logic          rst_n_i,
    input  a2_bus_t       bus_i,
    input  logic          aux_mem_i,
    input  logic          video_rd_i,
    output shadow_write_t wr_o
);

    shadow_region_e            region_d;
    logic [`TEXT_RAM_AW-1:0]   text_off;
    logic [`HIRES_RAM_AW-1:0]  hires_off;
    logic [15:0]               hires_rel;
    logic                      bank_aux;
    logic                      shadow_strobe;

    // Pending write
    logic                      pending_q;
    shadow_region_e            region_q;
    logic [11:0]               offset_q;
    logic [1:0]                lane_q;
    logic                      aux_q;
    logic [7:0]                data_q;

    assign bank_aux = aux_mem_i || bus_i.m2b0;

    always_comb begin
        region_d = REGION_NONE;
        if ((bus_i.addr >= `TEXT_LO) && (bus_i.addr <= `TEXT_HI)) begin
            region_d = REGION_TEXT;
        end else if ((bus_i.addr >= `HIRES_LO) && (bus_i.addr <= `HIRES_HI)) begin
            region_d = REGION_HIRES;
        end
    end

    // Text words hold two columns, each as a main/aux byte pair
    assign text_off  = {!bus_i.addr[10], bus_i.addr[9:1]};
    assign hires_rel = bus_i.addr - `HIRES_LO;
    assign hires_off = hires_rel[`HIRES_RAM_AW+1:2];

    assign shadow_strobe = bus_i.data_in_strobe && !bus_i.rw_n && (region_d != REGION_NONE);

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (shadow_strobe) begin
            pending_q <= 1'b1;
        end else if (!video_rd_i) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge a2bus_if) begin
        if (shadow_strobe) begin
            region_q <= region_d;
            aux_q    <= bank_aux;
            data_q   <= bus_i.data;
            if (region_d == REGION_TEXT) begin
                offset_q <= 12'(text_off);
                lane_q   <= {bus_i.addr[0], bank_aux};
            end else begin
                offset_q <= hires_off;
                lane_q   <= hires_rel[1:0];
            end
        end
    end

    assign wr_o = '{region: region_q, offset: offset_q, lane: lane_q, aux: aux_q,
                    data: data_q, valid: pending_q && !video_rd_i, spare: 2'b00};

    a_single_pending: assert property (
        @(posedge a2bus_if) disable iff (!rst_n_i)
        pending_q |-> !shadow_strobe
    );

endmodule

// File: test/shadow_vectors.txt
// op_flags_addr_data_expected; op 1 write, 2 read, 3 II, 4 IIe, 5 key,
// 6 video read, 7 write under video read, F end; flags bit 0 is m2b0
3_0_0000_00_00000081
4_0_0000_00_00000000
5_0_0000_00_00000000
// II switches
2_0_C050_00_00000000
3_0_0000_00_00000080
1_0_C053_00_00000000
3_0_0000_00_00000082
2_0_C057_00_00000000
2_0_C05E_00_00000000
3_0_0000_00_0000000A
2_0_C051_00_00000000
2_0_C052_00_00000000
2_0_C05F_00_00000000
3_0_0000_00_00000089
// IIe switches, a read at C000 changes nothing
1_0_C001_00_00000000
1_0_C009_00_00000000
4_0_0000_00_00000011
2_0_C000_00_00000001
4_0_0000_00_00000011
1_0_C008_00_00000001
4_0_0000_00_00000001
// Aux decode
2_0_0400_00_00000000
2_0_C055_00_00000000
3_0_0000_00_0000008D
2_0_0400_00_00000001
2_0_2000_00_00000001
2_0_C056_00_00000000
2_0_2000_00_00000000
1_0_C000_00_00000000
2_0_0400_00_00000000
1_0_C005_00_00000000
2_0_0800_00_00000000
1_0_0800_5A_00000001
2_0_0000_00_00000000
1_0_C009_00_00000000
2_0_0000_00_00000001
1_0_C008_00_00000001
1_0_C004_00_00000000
4_0_0000_00_00000000
// Text word 0800-0801, aux lane 1 came through ramwrt above
1_0_0801_3C_00000000
1_1_0801_C3_00000000
1_0_0800_11_00000000
6_0_0800_00_C33C5A11
6_0_0801_00_C33C5A11
// Hires word 2000-2003 in both banks
1_0_2000_20_00000000
1_0_2001_21_00000000
1_0_2002_22_00000000
1_0_2003_23_00000000
1_1_2000_A0_00000000
1_1_2001_A1_00000000
1_1_2002_A2_00000000
1_1_2003_A3_00000000
6_0_2000_00_A121A020
6_0_2002_00_A323A222
6_0_1000_00_00000000
// Keyboard
2_0_C000_C1_00000000
5_0_0000_00_00000183
2_0_C000_C2_00000000
5_0_0000_00_00000182
2_0_C010_00_00000000
5_0_0000_00_00000082
// Writes held back by scanner reads
7_0_0BFE_44_00000000
7_1_0BFE_55_00000000
7_0_0BFF_66_00000000
7_1_0BFF_77_00000000
6_0_0BFE_00_77665544
F_0_0000_00_00000000

// File: test/tb_apple_shadow.sv
/*
 * Vector-driven testbench for the Apple II video shadow.
 * Vectors come from test/shadow_vectors.txt; the first op F line ends
 * the list. Idle gaps and scanner read lengths come from an LFSR.
 * Unwritten shadow RAM reads as X, so read vectors only touch words
 * whose four lanes were all written.
 */
`timescale 1ns/1ps

module tb_apple_shadow
    import a2_shadow_pkg::*;
();

    localparam int MAX_VEC = 256;
    localparam int CLK_NS  = 40;

    logic          a2bus_if;
    logic          rst_n_i;
    a2_bus_t       bus_i;
    video_req_t    video_i;
    ii_switches_t  ii_sw_o;
    iie_switches_t iie_sw_o;
    logic          aux_mem_o;
    key_t          key_o;
    logic [31:0]   video_data_o;

    // op, flags, addr, data, expected
    logic [63:0]   vec_mem [MAX_VEC];
    int            nvec;
    logic          vec_ready;
    logic [31:0]   lfsr;

    apple_shadow_top dut (
        .a2bus_if     (a2bus_if),
        .rst_n_i      (rst_n_i),
        .bus_i        (bus_i),
        .video_i      (video_i),
        .ii_sw_o      (ii_sw_o),
        .iie_sw_o     (iie_sw_o),
        .aux_mem_o    (aux_mem_o),
        .key_o        (key_o),
        .video_data_o (video_data_o)
    );

    initial begin
        a2bus_if = 1'b0;
        forever #(CLK_NS / 2) a2bus_if = ~a2bus_if;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic stop_on_failure();
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_ii(input ii_switches_t got, input ii_switches_t exp);
        if (got !== exp) begin
            $display("** Error: ii_sw_o got 0x%h expected 0x%h", got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_iie(input iie_switches_t got, input iie_switches_t exp);
        if (got !== exp) begin
            $display("** Error: iie_sw_o got 0x%h expected 0x%h", got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_key(input key_t got, input key_t exp);
        if (got !== exp) begin
            $display("** Error: key_o got 0x%h expected 0x%h", got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_aux(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: aux_mem_o got 0x%h expected 0x%h", got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_video(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: video_data_o got 0x%h expected 0x%h", got, exp);
            stop_on_failure();
        end
    endtask

    task automatic idle_gap();
        int g;
        rand_bits(2, g);
        repeat (g) @(posedge a2bus_if);
    endtask

    // One strobed bus cycle; aux is checked while the bus is driven
    task automatic bus_cycle(input logic rw_n, input logic m2b0, input logic [15:0] addr,
                             input logic [7:0] data, input logic exp_aux);
        @(posedge a2bus_if);
        bus_i <= '{addr: addr, data: data, rw_n: rw_n, data_in_strobe: 1'b1,
                   phi1_posedge: 1'b1, m2sel_n: 1'b0, m2b0: m2b0};
        @(negedge a2bus_if);
        check_aux(aux_mem_o, exp_aux);
        @(posedge a2bus_if);
        bus_i <= '{addr: 16'h0000, data: 8'h00, rw_n: 1'b1, data_in_strobe: 1'b0,
                   phi1_posedge: 1'b0, m2sel_n: 1'b1, m2b0: 1'b0};
        @(negedge a2bus_if);
    endtask

    task automatic video_read(input logic [15:0] addr, input logic [31:0] exp);
        int k;
        rand_bits(2, k);
        k = (k % 3) + 1;
        @(posedge a2bus_if);
        video_i <= '{addr: addr, rd: 1'b1};
        repeat (k) @(posedge a2bus_if);
        video_i <= '{addr: addr, rd: 1'b0};
        @(negedge a2bus_if);
        check_video(video_data_o, exp);
    endtask

    // Write strobed while the scanner holds rd high on text page 1
    task automatic write_under_read(input logic m2b0, input logic [15:0] addr,
                                    input logic [7:0] data, input logic exp_aux);
        int k;
        rand_bits(2, k);
        k = (k % 3) + 1;
        @(posedge a2bus_if);
        video_i <= '{addr: 16'h0400, rd: 1'b1};
        bus_cycle(1'b0, m2b0, addr, data, exp_aux);
        repeat (k) @(posedge a2bus_if);
        video_i <= '{addr: 16'h0400, rd: 1'b0};
        @(negedge a2bus_if);
    endtask

    initial begin
        logic [3:0]  op;
        logic [3:0]  flags;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [31:0] exp;

        rst_n_i   = 1'b0;
        bus_i     = '{addr: 16'h0000, data: 8'h00, rw_n: 1'b1, data_in_strobe: 1'b0,
                      phi1_posedge: 1'b0, m2sel_n: 1'b1, m2b0: 1'b0};
        video_i   = '{addr: 16'h0000, rd: 1'b0};
        lfsr      = 32'h7995_a845;
        vec_ready = 1'b0;
        nvec      = 0;

        $readmemh("test/shadow_vectors.txt", vec_mem);
        while ((nvec < MAX_VEC) && (vec_mem[nvec][63:60] !== 4'hF)) begin
            nvec++;
        end
        if (nvec == MAX_VEC) begin
            $display("Vector file has no end marker or could not be read");
            stop_on_failure();
        end

        repeat (8) @(posedge a2bus_if);
        rst_n_i <= 1'b1;
        @(negedge a2bus_if);
        vec_ready = 1'b1;

        for (int i = 0; i < nvec; i++) begin
            op    = vec_mem[i][63:60];
            flags = vec_mem[i][59:56];
            addr  = vec_mem[i][55:40];
            data  = vec_mem[i][39:32];
            exp   = vec_mem[i][31:0];
            case (op)
                4'h1: begin
                    idle_gap();
                    bus_cycle(1'b0, flags[0], addr, data, exp[0]);
                end
                4'h2: begin
                    idle_gap();
                    bus_cycle(1'b1, flags[0], addr, data, exp[0]);
                end
                4'h3: check_ii(ii_sw_o, ii_switches_t'(exp[7:0]));
                4'h4: check_iie(iie_sw_o, iie_switches_t'(exp[7:0]));
                4'h5: check_key(key_o, key_t'(exp[8:0]));
                4'h6: begin
                    idle_gap();
                    video_read(addr, exp);
                end
                4'h7: begin
                    idle_gap();
                    write_under_read(flags[0], addr, data, exp[0]);
                end
                default: begin
                    $display("Vector %0d has an unknown operation code %h", i, op);
                    stop_on_failure();
                end
            endcase
        end

        $display("Testbench passed");
        $finish;
    end

    // Budget of eight clock cycles per vector on average
    initial begin
        wait (vec_ready);
        #(nvec * 8 * CLK_NS);
        $display("Timeout: the vectors did not complete within the time allowed");
        stop_on_failure();
    end

endmodule

// File: vlog.f
+incdir+include
source/a2_shadow_pkg.sv
source/soft_switches.sv
source/keyboard_latch.sv
source/write_scheduler.sv
source/sdpram32.sv
source/video_shadow.sv
source/apple_shadow_top.sv
test/tb_apple_shadow.sv
